// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    // RV32I major opcodes handled by this core
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10   // LUI result
    } alu_op_e;

    typedef enum logic [2:0] {
        imm_i = 3'd0,
        imm_s = 3'd1,
        imm_b = 3'd2,
        imm_u = 3'd3,
        imm_j = 3'd4
    } imm_fmt_e;

    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_mem = 2'd1,
        wb_pc4 = 2'd2        // Link address for jumps
    } wb_sel_e;

    typedef struct packed {
        logic       write_en;
        wb_sel_e    wb_sel;
        logic       rd_en;        // Load
        logic       wrt_en;       // Store
        logic [1:0] width;        // Byte, half, word
        logic       unsigned_sel;
        alu_op_e    alu_op;
        logic [3:0] bj_inst;      // {jump, funct3}
        logic       jalr;
        logic       alu_src_imm;
    } ctrl_t;

    typedef struct packed {
        logic                  write_enable;
        logic [reg_addr_w-1:0] write_reg;
        logic [xlen-1:0]       write_data;
    } wb_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [xlen-1:0]       read_data1;   // Operand A, PC for AUIPC
        logic [xlen-1:0]       read_data2;
        logic [xlen-1:0]       imm;
        logic [xlen-1:0]       next_pc;
        logic [reg_addr_w-1:0] read_register1;
        logic [reg_addr_w-1:0] read_register2;
        logic [reg_addr_w-1:0] write_reg;
        logic [31:0]           instruction;
    } id_ex_t;

endpackage

`default_nettype wire

// ==== hw/register_file.sv ====
`default_nettype none

module register_file
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] src_reg1,
    input  logic [reg_addr_w-1:0] src_reg2,
    input  wb_t                   wb,
    output logic [xlen-1:0]       src_data1,
    output logic [xlen-1:0]       src_data2
);

    logic [xlen-1:0] regs [num_regs];
    logic            hit1;
    logic            hit2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.write_enable && wb.write_reg != '0) begin
            regs[wb.write_reg] <= wb.write_data;
        end
    end

    // Write in the same cycle wins over the stored value
    assign hit1 = wb.write_enable && (wb.write_reg == src_reg1);
    assign hit2 = wb.write_enable && (wb.write_reg == src_reg2);

    assign src_data1 = (src_reg1 == '0) ? '0 :
                       hit1             ? wb.write_data :
                                          regs[src_reg1];

    assign src_data2 = (src_reg2 == '0) ? '0 :
                       hit2             ? wb.write_data :
                                          regs[src_reg2];

endmodule

`default_nettype wire

// ==== hw/instruction_decoder.sv ====
`default_nettype none

module instruction_decoder
    import core_pkg::*;
(
    input  logic [31:0] instruction,
    output ctrl_t       ctrl,
    output imm_fmt_e    imm_fmt,
    output logic        uses_rs1,
    output logic        uses_rs2,
    output logic        illegal
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    // alt selects SUB / SRA
    function automatic alu_op_e funct3_to_alu(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl        = '0;
        ctrl.wb_sel = wb_alu;
        ctrl.alu_op = alu_add;
        imm_fmt     = imm_i;
        uses_rs1    = 1'b0;
        uses_rs2    = 1'b0;
        illegal     = 1'b0;

        case (opcode)
            op_load: begin
                ctrl.write_en     = 1'b1;
                ctrl.wb_sel       = wb_mem;
                ctrl.rd_en        = 1'b1;
                ctrl.width        = funct3[1:0];
                ctrl.unsigned_sel = funct3[2];
                ctrl.alu_src_imm  = 1'b1;  // Address = rs1 + imm
                uses_rs1          = 1'b1;
            end
            op_store: begin
                ctrl.wrt_en      = 1'b1;
                ctrl.width       = funct3[1:0];
                ctrl.alu_src_imm = 1'b1;
                imm_fmt          = imm_s;
                uses_rs1         = 1'b1;
                uses_rs2         = 1'b1;
            end
            op_branch: begin
                ctrl.alu_op  = alu_sub;
                ctrl.bj_inst = {1'b0, funct3};
                imm_fmt      = imm_b;
                uses_rs1     = 1'b1;
                uses_rs2     = 1'b1;
            end
            op_jal: begin
                ctrl.write_en    = 1'b1;
                ctrl.wb_sel      = wb_pc4;
                ctrl.bj_inst     = 4'b1000;
                ctrl.alu_src_imm = 1'b1;
                imm_fmt          = imm_j;
            end
            op_jalr: begin
                ctrl.write_en    = 1'b1;
                ctrl.wb_sel      = wb_pc4;
                ctrl.bj_inst     = 4'b1000;
                ctrl.jalr        = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                uses_rs1         = 1'b1;
            end
            op_imm: begin
                ctrl.write_en    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = funct3_to_alu(funct3, funct3 == 3'b101 && funct7[5]);
                uses_rs1         = 1'b1;
            end
            op_reg: begin
                ctrl.write_en = 1'b1;
                ctrl.alu_op   = funct3_to_alu(funct3, funct7[5]);
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
                // Only ADD/SUB and SRL/SRA have an alternate encoding
                if (funct7 == 7'b0100000) begin
                    illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
                end else if (funct7 != 7'b0000000) begin
                    illegal = 1'b1;
                end
            end
            op_lui: begin
                ctrl.write_en    = 1'b1;
                ctrl.alu_op      = alu_pass_b;
                ctrl.alu_src_imm = 1'b1;
                imm_fmt          = imm_u;
            end
            op_auipc: begin
                ctrl.write_en    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm_fmt          = imm_u;
            end
            default: begin
                illegal = 1'b1;  // CSR, FENCE, system and unknown
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/hazard_unit.sv ====
`default_nettype none

module hazard_unit
    import core_pkg::*;
(
    input  logic                  ex_load,
    input  logic [reg_addr_w-1:0] ex_write_reg,
    input  logic [reg_addr_w-1:0] src_reg1,
    input  logic [reg_addr_w-1:0] src_reg2,
    input  logic                  uses_rs1,
    input  logic                  uses_rs2,
    output logic                  hazard
);

    logic match1;
    logic match2;
    logic ex_live;

    // A load into x0 never produces data worth waiting for
    assign ex_live = ex_load && (ex_write_reg != '0);

    assign match1 = uses_rs1 && (src_reg1 == ex_write_reg);
    assign match2 = uses_rs2 && (src_reg2 == ex_write_reg);

    assign hazard = ex_live && (match1 || match2);

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`default_nettype none

module decode_stage
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall_mem,
    input  logic            flush,
    input  logic            hazard,
    input  logic            illegal,
    input  logic [31:0]     instruction,
    input  logic [xlen-1:0] next_pc,
    input  ctrl_t           ctrl,
    input  imm_fmt_e        imm_fmt,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    output id_ex_t          id_ex
);

    logic [xlen-1:0] imm;
    logic [xlen-1:0] operand_a;
    logic            is_auipc;
    logic            bubble;
    id_ex_t          id_ex_d;

    // Sign extended immediates, RV32I bit placement
    always_comb begin
        case (imm_fmt)
            imm_s: imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            imm_b: imm = {{19{instruction[31]}}, instruction[31], instruction[7],
                          instruction[30:25], instruction[11:8], 1'b0};
            imm_u: imm = {instruction[31:12], 12'b0};
            imm_j: imm = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                          instruction[20], instruction[30:21], 1'b0};
            default: imm = {{20{instruction[31]}}, instruction[31:20]};
        endcase
    end

    assign is_auipc  = (ctrl.alu_op == alu_add) &&
                       (opcode_e'(instruction[6:0]) == op_auipc);
    assign operand_a = is_auipc ? next_pc : rs1_data;

    always_comb begin
        id_ex_d                = '0;
        id_ex_d.valid          = 1'b1;
        id_ex_d.ctrl           = ctrl;
        id_ex_d.read_data1     = operand_a;
        id_ex_d.read_data2     = rs2_data;
        id_ex_d.imm            = imm;
        id_ex_d.next_pc        = next_pc;
        id_ex_d.read_register1 = instruction[19:15];
        id_ex_d.read_register2 = instruction[24:20];
        id_ex_d.write_reg      = instruction[11:7];
        id_ex_d.instruction    = instruction;
    end

    assign bubble = hazard || flush || illegal;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!stall_mem) begin  // Stall holds the whole word
            if (bubble) begin
                id_ex <= '0;
            end else begin
                id_ex <= id_ex_d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/decode_top.sv ====
`default_nettype none

module decode_top
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            stall_mem,
    input  logic [31:0]     instruction,
    input  logic [xlen-1:0] next_pc,
    input  wb_t             wb,
    output id_ex_t          id_ex,
    output logic            stall_fetch
);

    ctrl_t           ctrl;
    imm_fmt_e        imm_fmt;
    logic            uses_rs1;
    logic            uses_rs2;
    logic            illegal;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;

    register_file regfile0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .src_reg1  (instruction[19:15]),
        .src_reg2  (instruction[24:20]),
        .wb        (wb),
        .src_data1 (rs1_data),
        .src_data2 (rs2_data)
    );

    instruction_decoder decoder0 (
        .instruction (instruction),
        .ctrl        (ctrl),
        .imm_fmt     (imm_fmt),
        .uses_rs1    (uses_rs1),
        .uses_rs2    (uses_rs2),
        .illegal     (illegal)
    );

    // Load in EX is taken straight from the ID/EX word
    hazard_unit hazard0 (
        .ex_load      (id_ex.ctrl.rd_en),
        .ex_write_reg (id_ex.write_reg),
        .src_reg1     (instruction[19:15]),
        .src_reg2     (instruction[24:20]),
        .uses_rs1     (uses_rs1),
        .uses_rs2     (uses_rs2),
        .hazard       (stall_fetch)
    );

    decode_stage stage0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_mem   (stall_mem),
        .flush       (flush),
        .hazard      (stall_fetch),
        .illegal     (illegal),
        .instruction (instruction),
        .next_pc     (next_pc),
        .ctrl        (ctrl),
        .imm_fmt     (imm_fmt),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .id_ex       (id_ex)
    );

endmodule

`default_nettype wire

// ==== verif/decode_tb.sv ====
`default_nettype none

module decode_tb
    import core_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int reset_cycles = 10;
    localparam int stim_cycles  = 450;   // Directed plus 300 random and their bubbles
    localparam int cycle_limit  = 2 * stim_cycles + reset_cycles;
    localparam logic [31:0] nop = 32'h0000_0013;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        flush;
    logic        stall_mem;
    logic [31:0] instruction;
    logic [31:0] next_pc;
    wb_t         wb;
    id_ex_t      id_ex;
    logic        stall_fetch;

    logic [31:0] mirror [num_regs];
    id_ex_t      exp_id_ex;
    int          cycle_count = 0;
    int          error_count = 0;

    decode_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .stall_mem   (stall_mem),
        .instruction (instruction),
        .next_pc     (next_pc),
        .wb          (wb),
        .id_ex       (id_ex),
        .stall_fetch (stall_fetch)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic alu_op_e alu_for(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // Control, immediate and source use as RV32I defines them
    function automatic void ref_ctrl(input logic [31:0] ins, output ctrl_t c,
                                     output logic [31:0] imm, output logic u1,
                                     output logic u2, output logic bad);
        logic [2:0] f3;
        logic [6:0] f7;
        f3  = ins[14:12];
        f7  = ins[31:25];
        c   = '0;
        imm = {{20{ins[31]}}, ins[31:20]};
        u1  = 1'b0;
        u2  = 1'b0;
        bad = 1'b0;
        case (ins[6:0])
            op_load: begin
                c = '{write_en: 1'b1, wb_sel: wb_mem, rd_en: 1'b1, wrt_en: 1'b0,
                      width: f3[1:0], unsigned_sel: f3[2], alu_op: alu_add,
                      bj_inst: 4'b0, jalr: 1'b0, alu_src_imm: 1'b1};
                u1 = 1'b1;
            end
            op_store: begin
                c.wrt_en      = 1'b1;
                c.width       = f3[1:0];
                c.alu_src_imm = 1'b1;
                imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                u1  = 1'b1;
                u2  = 1'b1;
            end
            op_branch: begin
                c.alu_op  = alu_sub;
                c.bj_inst = {1'b0, f3};
                imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                u1  = 1'b1;
                u2  = 1'b1;
            end
            op_jal, op_jalr: begin
                c.write_en    = 1'b1;
                c.wb_sel      = wb_pc4;
                c.bj_inst     = 4'b1000;  // Jump flag
                c.alu_src_imm = 1'b1;
                c.jalr        = (ins[6:0] == op_jalr);
                u1            = (ins[6:0] == op_jalr);
                if (ins[6:0] == op_jal) begin
                    imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
            end
            op_imm: begin
                c.write_en    = 1'b1;
                c.alu_src_imm = 1'b1;
                c.alu_op      = alu_for(f3, f3 == 3'b101 && f7[5]);
                u1 = 1'b1;
            end
            op_reg: begin
                c.write_en = 1'b1;
                c.alu_op   = alu_for(f3, f7[5]);
                u1  = 1'b1;
                u2  = 1'b1;
                bad = !(f7 == 7'b0 || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101)));
            end
            op_lui, op_auipc: begin
                c.write_en    = 1'b1;
                c.alu_src_imm = 1'b1;
                c.alu_op      = (ins[6:0] == op_lui) ? alu_pass_b : alu_add;
                imm = {ins[31:12], 12'h000};
            end
            default: bad = 1'b1;
        endcase
    endfunction

    function automatic logic ref_hazard(input logic [31:0] ins, input id_ex_t ex);
        ctrl_t       c;
        logic [31:0] imm;
        logic        u1;
        logic        u2;
        logic        bad;
        ref_ctrl(ins, c, imm, u1, u2, bad);
        return ex.ctrl.rd_en && ex.write_reg != 5'd0 &&
               ((u1 && ins[19:15] == ex.write_reg) || (u2 && ins[24:20] == ex.write_reg));
    endfunction

    function automatic logic [31:0] read_reg(input logic [4:0] idx);
        if (idx == 5'd0) return 32'h0;
        if (wb.write_enable && wb.write_reg == idx) return wb.write_data;  // Bypass
        return mirror[idx];
    endfunction

    function automatic id_ex_t ref_decode(input logic [31:0] ins, input logic [31:0] pc,
                                          input logic [31:0] v1, input logic [31:0] v2,
                                          input logic hold, input logic kill,
                                          input id_ex_t prev);
        id_ex_t      e;
        logic        u1;
        logic        u2;
        logic        bad;
        if (hold) return prev;
        e = '0;
        ref_ctrl(ins, e.ctrl, e.imm, u1, u2, bad);
        if (kill || bad) return '0;
        e.valid          = 1'b1;
        e.read_data1     = (ins[6:0] == op_auipc) ? pc : v1;
        e.read_data2     = v2;
        e.next_pc        = pc;
        e.read_register1 = ins[19:15];
        e.read_register2 = ins[24:20];
        e.write_reg      = ins[11:7];
        e.instruction    = ins;
        return e;
    endfunction

    task automatic report_failure();
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_id_ex(input id_ex_t got, input id_ex_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("Mismatch at time %0t: %s, got %h, expected %h", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic check_stall(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("Mismatch at time %0t: %s, got %b, expected %b", $time, what, got, exp);
            report_failure();
        end
    endtask

    // Reference model steps on the same edge as the DUT
    always @(posedge clk) begin : model
        id_ex_t nxt;
        logic   hz;
        hz = ref_hazard(instruction, exp_id_ex);
        if (!rst_n) begin
            nxt = '0;
            for (int i = 0; i < num_regs; i++) begin
                mirror[i] = 32'h0;
            end
        end else begin
            nxt = ref_decode(instruction, next_pc, read_reg(instruction[19:15]),
                             read_reg(instruction[24:20]), stall_mem, flush || hz, exp_id_ex);
            if (wb.write_enable && wb.write_reg != 5'd0) begin
                mirror[wb.write_reg] = wb.write_data;
            end
        end
        exp_id_ex <= nxt;
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the test did not finish within %0d cycles", cycle_limit);
            report_failure();
        end
    end

    always @(negedge clk) begin
        if (cycle_count > 0) begin
            check_id_ex(id_ex, exp_id_ex, "id_ex against reference");
            check_stall(stall_fetch, ref_hazard(instruction, exp_id_ex), "stall_fetch");
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] random_instr(input logic [31:0] r);
        logic [31:0] ins;
        ins = r;
        case (r % 32'd9)
            32'd0:   ins[6:0] = op_load;
            32'd1:   ins[6:0] = op_store;
            32'd2:   ins[6:0] = op_branch;
            32'd3:   ins[6:0] = op_jal;
            32'd4:   ins[6:0] = op_jalr;
            32'd5:   ins[6:0] = op_imm;
            32'd6:   ins[6:0] = op_reg;
            32'd7:   ins[6:0] = op_lui;
            default: ins[6:0] = op_auipc;
        endcase
        if (ins[6:0] == op_reg) begin  // Keep funct7 legal
            ins[31:25] = (ins[14:12] == 3'b000 || ins[14:12] == 3'b101) ?
                         {1'b0, r[30], 5'b0} : 7'b0;
        end
        return ins;
    endfunction

    task automatic drive_cycle(input logic [31:0] ins, input logic [31:0] pc,
                               input logic fl, input logic st, input wb_t w);
        @(posedge clk);
        instruction <= ins;
        next_pc     <= pc;
        flush       <= fl;
        stall_mem   <= st;
        wb          <= w;
        @(negedge clk);
    endtask

    task automatic issue(input logic [31:0] ins, input logic [31:0] pc, input wb_t w);
        drive_cycle(ins, pc, 1'b0, 1'b0, w);
        while (stall_fetch) begin  // Re-present through the bubble
            @(negedge clk);
        end
    endtask

    initial begin : stimulus
        logic [31:0] pc;
        logic [31:0] rng;
        wb_t         w;
        id_ex_t      held;
        rst_n       = 1'b0;
        flush       = 1'b0;
        stall_mem   = 1'b0;
        instruction = nop;
        next_pc     = 32'h0;
        wb          = '0;
        pc          = 32'h0000_1000;
        rng         = 32'd64039;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_id_ex(id_ex, '0, "id_ex after reset");
        check_stall(stall_fetch, 1'b0, "stall_fetch after reset");

        for (int i = 0; i < num_regs; i++) begin
            w = '{write_enable: 1'b1, write_reg: 5'(i), write_data: 32'h9e3779b9 * (i + 1)};
            issue(nop, pc, w);
        end
        for (int i = 0; i < num_regs; i += 2) begin
            issue(r_type(7'b0, 5'(i + 1), 5'(i), 3'b000, 5'd3), pc, '0);
        end
        w = '{write_enable: 1'b1, write_reg: 5'd8, write_data: 32'hcafe_f00d};
        issue(r_type(7'b0, 5'd9, 5'd8, 3'b000, 5'd1), pc, w);
        issue(r_type(7'b0100000, 5'd8, 5'd9, 3'b000, 5'd2), pc, '0);
        w = '{write_enable: 1'b1, write_reg: 5'd0, write_data: 32'hdead_beef};
        issue(r_type(7'b0, 5'd0, 5'd0, 3'b000, 5'd4), pc, w);
        issue(r_type(7'b0, 5'd0, 5'd0, 3'b110, 5'd4), pc, '0);

        for (int n = 0; n < 300; n++) begin
            rng = xorshift(rng);
            w.write_enable = rng[0];
            w.write_reg    = rng[5:1];
            rng = xorshift(rng);
            w.write_data   = rng;
            rng = xorshift(rng);
            issue(random_instr(rng), pc, w);
            pc = pc + 32'd4;
        end

        issue(nop, pc, '0);
        drive_cycle(r_type(7'b0, 5'd2, 5'd1, 3'b000, 5'd3), pc, 1'b1, 1'b0, '0);
        drive_cycle(nop, pc, 1'b0, 1'b0, '0);
        check_id_ex(id_ex, '0, "bubble after flush");
        drive_cycle(32'h0000_0073, pc, 1'b0, 1'b0, '0);               // ECALL
        drive_cycle(r_type(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3), pc, 1'b0, 1'b0, '0);
        check_id_ex(id_ex, '0, "bubble for system opcode");
        drive_cycle(nop, pc, 1'b0, 1'b0, '0);
        check_id_ex(id_ex, '0, "bubble for illegal funct7");

        issue({12'h123, 5'd1, 3'b000, 5'd4, op_imm}, 32'h0000_2000, '0);
        drive_cycle(r_type(7'b0, 5'd5, 5'd6, 3'b100, 5'd7), 32'h0000_2004, 1'b0, 1'b1, '0);
        held = exp_id_ex;
        for (int k = 0; k < 4; k++) begin
            drive_cycle(nop + 32'(k << 20), 32'h0000_3000, k[0], 1'b1, '0);
            check_id_ex(id_ex, held, "id_ex held during stall");
        end
        issue(r_type(7'b0, 5'd5, 5'd6, 3'b100, 5'd7), 32'h0000_2004, '0);
        issue(nop, pc, '0);

        issue({12'd8, 5'd1, 3'b010, 5'd5, op_load}, pc, '0);
        drive_cycle(r_type(7'b0, 5'd2, 5'd5, 3'b000, 5'd6), pc, 1'b0, 1'b0, '0);
        check_stall(stall_fetch, 1'b1, "load-use on rs1");
        @(negedge clk);
        check_id_ex(id_ex, '0, "load-use bubble");
        check_stall(stall_fetch, 1'b0, "stall_fetch after bubble");
        issue({12'd4, 5'd1, 3'b010, 5'd5, op_load}, pc, '0);
        issue(r_type(7'b0, 5'd5, 5'd2, 3'b000, 5'd6), pc, '0);        // Hazard on rs2
        issue({12'd0, 5'd1, 3'b010, 5'd7, op_load}, pc, '0);
        drive_cycle({20'h00038, 5'd3, op_lui}, pc, 1'b0, 1'b0, '0);
        check_stall(stall_fetch, 1'b0, "LUI after load");
        issue({12'd0, 5'd1, 3'b010, 5'd7, op_load}, pc, '0);
        drive_cycle({20'h00038, 5'd1, op_jal}, pc, 1'b0, 1'b0, '0);
        check_stall(stall_fetch, 1'b0, "JAL after load");
        issue({12'd0, 5'd1, 3'b010, 5'd0, op_load}, pc, '0);
        drive_cycle(r_type(7'b0, 5'd0, 5'd0, 3'b000, 5'd6), pc, 1'b0, 1'b0, '0);
        check_stall(stall_fetch, 1'b0, "load to x0");
        repeat (3) issue(nop, pc, '0);

        if (error_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            report_failure();
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
hw/core_pkg.sv
hw/register_file.sv
hw/instruction_decoder.sv
hw/hazard_unit.sv
hw/decode_stage.sv
hw/decode_top.sv
verif/decode_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module decode_tb -f build.f -o decode_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/decode_sim > sim.log 2>&1 || true
cat sim.log
grep -q '\*\*\* PASSED \*\*\*' sim.log && exit 0 || exit 1
